//--- operand_unit.f
+incdir+verification
common/ncpu_pkg.sv
logic/sdpram_sclk.sv
regfile/regfile.sv
regfile/operand_fetch.sv
logic/operand_unit.sv
verification/tb_operand_unit.sv

//--- Bender.yml
package:
  name: operand_unit

sources:
  # Register-file read stage, package first.
  - files:
      - common/ncpu_pkg.sv
      - logic/sdpram_sclk.sv
      - regfile/regfile.sv
      - regfile/operand_fetch.sv
      - logic/operand_unit.sv

  # Testbench with its included helper file.
  - target: test
    include_dirs:
      - verification
    files:
      - verification/tb_operand_unit.sv

//--- verification/tb_checks.svh
////////////////////
// Testbench helpers for the register-file read stage.
// Register model, input drivers, typed compares and directed tests.
////////////////////

// Software copy of the register file, updated with each write.
logic [xlen-1:0] model_regs [32];

// Advance to the drive point of the next cycle.
task automatic tick();
   @(posedge clk);
   #drive_dly;
endtask

// Waits until the stage can take an instruction.
task automatic wait_issue_ready(input string test);
   int n;
   n = 0;
   while (!issue_ready && n < wait_limit) begin
      tick();
      n++;
   end
   if (!issue_ready) begin
      $display("%s: issue_ready stayed low for %0d cycles", test, wait_limit);
      $display("Checks failed");
      $fatal(1, "Timeout waiting for issue_ready");
   end
endtask

task automatic check_operand(input string test, input operand_t expected, input operand_t actual);
   if (actual !== expected) begin
      $display("ERR %s: expected %h actual %h", test, expected, actual);
      $display("Checks failed");
      $fatal(1, "Operand mismatch");
   end
endtask

task automatic check_flag(input string test, input string name, input logic expected,
                          input logic actual);
   if (actual !== expected) begin
      $display("ERR %s %s: expected %b actual %b", test, name, expected, actual);
      $display("Checks failed");
      $fatal(1, "Control bit mismatch");
   end
endtask

// Operand expected from the model. Register 0 always gives zero.
function automatic operand_t model_operand(input op_e op, input reg_idx_t rd,
                                           input reg_idx_t rs1, input reg_idx_t rs2);
   operand_t expected;
   expected.opcode  = op;
   expected.rd      = rd;
   expected.rs1_val = (rs1 == '0) ? '0 : model_regs[rs1];
   expected.rs2_val = (rs2 == '0) ? '0 : model_regs[rs2];
   return expected;
endfunction

// Puts a write on the port for the coming edge.
// The model takes it right away; writes to register 0 are dropped.
task automatic drive_write(input reg_idx_t r, input logic [xlen-1:0] data);
   wb.we   = 1'b1;
   wb.rd   = r;
   wb.data = data;
   if (r != '0) begin
      model_regs[r] = data;
   end
endtask

// Offers one instruction, once the stage is ready.
task automatic drive_issue(input string test, input op_e op, input reg_idx_t rs1,
                           input reg_idx_t rs2, input reg_idx_t rd);
   wait_issue_ready(test);
   issue.opcode = op;
   issue.rs1    = rs1;
   issue.rs2    = rs2;
   issue.rd     = rd;
   issue_valid  = 1'b1;
endtask

task automatic idle_inputs();
   issue_valid = 1'b0;
   wb.we       = 1'b0;
endtask

task automatic reset_defaults();
   check_flag("reset", "operand_valid", 1'b0, operand_valid);
   check_flag("reset", "issue_ready", 1'b1, issue_ready);
   check_operand("reset", '0, operand);
endtask

// Fills registers 1 to 31, then reads them back one issue per cycle.
task automatic fill_and_read();
   operand_t expected;
   for (int r = 1; r < 32; r++) begin
      drive_write(reg_idx_t'(r), $urandom());
      tick();
   end
   wb.we = 1'b0;
   // The two ports walk the file in opposite directions.
   for (int i = 0; i < 32; i++) begin
      drive_issue("write_read", op_e'(i % 5), reg_idx_t'(i), reg_idx_t'(31 - i),
                  reg_idx_t'(i));
      expected = model_operand(op_e'(i % 5), reg_idx_t'(i), reg_idx_t'(i),
                               reg_idx_t'(31 - i));
      tick();
      check_operand("write_read", expected, operand);
      check_flag("write_read", "operand_valid", 1'b1, operand_valid);
   end
   idle_inputs();
   tick();
endtask

task automatic reg_zero_reads();
   operand_t expected;
   // The write to register 0 lands in the same cycle as the read of it.
   drive_write('0, $urandom());
   drive_issue("reg_zero", op_alu, '0, '0, 5'd3);
   expected = model_operand(op_alu, 5'd3, '0, '0);
   tick();
   wb.we = 1'b0;
   check_operand("reg_zero", expected, operand);
   drive_issue("reg_zero", op_load, '0, 5'd7, 5'd4);
   expected = model_operand(op_load, 5'd4, '0, 5'd7);
   tick();
   check_operand("reg_zero", expected, operand);
   drive_issue("reg_zero", op_store, 5'd7, '0, 5'd5);
   expected = model_operand(op_store, 5'd5, 5'd7, '0);
   tick();
   check_operand("reg_zero", expected, operand);
   idle_inputs();
   tick();
endtask

task automatic same_cycle_forward();
   operand_t expected;
   drive_write(5'd9, $urandom());
   drive_issue("forward", op_branch, 5'd9, 5'd9, 5'd9);
   expected = model_operand(op_branch, 5'd9, 5'd9, 5'd9);
   tick();
   idle_inputs();
   check_operand("forward", expected, operand);
   check_flag("forward", "operand_valid", 1'b1, operand_valid);
   tick();
endtask

task automatic hold_freezes_output();
   operand_t expected;
   drive_issue("hold", op_load, 5'd17, 5'd3, 5'd6);
   expected = model_operand(op_load, 5'd6, 5'd17, 5'd3);
   tick();
   check_operand("hold", expected, operand);
   // A second instruction stays on offer and must not be taken.
   issue.rd = 5'd11;
   hold     = 1'b1;
   drive_write(5'd17, $urandom());
   tick();
   wb.we = 1'b0;
   for (int i = 0; i < 4; i++) begin
      check_flag("hold", "issue_ready", 1'b0, issue_ready);
      check_flag("hold", "operand_valid", 1'b1, operand_valid);
      check_operand("hold", expected, operand);
      tick();
   end
   hold        = 1'b0;
   issue_valid = 1'b0;
   tick();
   // The read after the hold sees the value written during it.
   drive_issue("hold", op_alu, 5'd17, 5'd17, 5'd8);
   expected = model_operand(op_alu, 5'd8, 5'd17, 5'd17);
   tick();
   check_operand("hold", expected, operand);
   idle_inputs();
   tick();
endtask

task automatic bubble_clears_valid();
   drive_issue("bubble", op_alu, 5'd2, 5'd4, 5'd1);
   tick();
   check_flag("bubble", "operand_valid", 1'b1, operand_valid);
   issue_valid = 1'b0;
   tick();
   check_flag("bubble", "operand_valid", 1'b0, operand_valid);
   drive_issue("bubble", op_store, 5'd4, 5'd2, 5'd1);
   tick();
   check_flag("bubble", "operand_valid", 1'b1, operand_valid);
   check_operand("bubble", model_operand(op_store, 5'd1, 5'd4, 5'd2), operand);
   idle_inputs();
   tick();
endtask

//--- verification/tb_operand_unit.sv
////////////////////
// Testbench for the register-file read stage.
// Drives issue, hold and writeback into the top level and checks
// the fetched operands against a register model.
////////////////////

module tb_operand_unit;

   import ncpu_pkg::*;

   // Inputs change this long after each rising clock edge.
   localparam int drive_dly = 2;

   // Longest number of cycles any single wait may take.
   localparam int wait_limit = 50;

   logic     clk;
   logic     rst_n;
   issue_t   issue;
   logic     issue_valid;
   logic     issue_ready;
   logic     hold;
   operand_t operand;
   logic     operand_valid;
   wb_t      wb;

   operand_unit u_operand_unit (
      .clk           (clk),
      .rst_n         (rst_n),
      .issue         (issue),
      .issue_valid   (issue_valid),
      .issue_ready   (issue_ready),
      .hold          (hold),
      .operand       (operand),
      .operand_valid (operand_valid),
      .wb            (wb)
   );

   // Free-running clock with a period of 20.
   always #10 clk = ~clk;

   // Model, drivers, compare tasks and the directed tests.
   `include "tb_checks.svh"

   initial begin
      clk         = 1'b0;
      rst_n       = 1'b0;
      issue       = '0;
      issue_valid = 1'b0;
      hold        = 1'b0;
      wb          = '0;

      // One seed for the whole run, so the write data repeats.
      void'($urandom(32'h79b7_86e0));

      // Register 0 is zero by definition, the rest gets written first.
      for (int i = 0; i < 32; i++) begin
         model_regs[i] = '0;
      end

      // Reset stays low for four full cycles.
      repeat (4) @(posedge clk);
      #drive_dly;
      rst_n = 1'b1;

      reset_defaults();
      fill_and_read();
      reg_zero_reads();
      same_cycle_forward();
      hold_freezes_output();
      bubble_clears_valid();

      $display("All checks passed");
      $finish;
   end

endmodule

//--- logic/operand_unit.sv
////////////////////
// Register-file read stage, top level.
// Connects the operand fetch stage to the register file.
////////////////////

module operand_unit (
   input  logic               clk,
   input  logic               rst_n,

   // Issue handshake.
   input  ncpu_pkg::issue_t   issue,
   input  logic               issue_valid,
   output logic               issue_ready,

   // Output to the next stage and its hold.
   input  logic               hold,
   output ncpu_pkg::operand_t operand,
   output logic               operand_valid,

   // Writeback port.
   input  ncpu_pkg::wb_t      wb
);

   import ncpu_pkg::*;

   // Read port between the fetch stage and the register file.
   reg_idx_t        raddr_a;
   reg_idx_t        raddr_b;
   logic            re;
   logic [xlen-1:0] rdata_a;
   logic [xlen-1:0] rdata_b;

   operand_fetch u_operand_fetch (
      .clk           (clk),
      .rst_n         (rst_n),
      .issue         (issue),
      .issue_valid   (issue_valid),
      .issue_ready   (issue_ready),
      .hold          (hold),
      .raddr_a       (raddr_a),
      .raddr_b       (raddr_b),
      .re            (re),
      .rdata_a       (rdata_a),
      .rdata_b       (rdata_b),
      .operand       (operand),
      .operand_valid (operand_valid)
   );

   // Writeback goes straight into the register file.
   regfile u_regfile (
      .clk     (clk),
      .rst_n   (rst_n),
      .raddr_a (raddr_a),
      .raddr_b (raddr_b),
      .re      (re),
      .wb      (wb),
      .rdata_a (rdata_a),
      .rdata_b (rdata_b)
   );

endmodule

//--- regfile/operand_fetch.sv
////////////////////
// Operand fetch pipeline stage.
// Takes one issued instruction per cycle, starts both register reads
// and presents the instruction with its operands one cycle later.
// A downstream hold freezes the output.
////////////////////

module operand_fetch (
   input  logic                      clk,
   input  logic                      rst_n,

   // Issue side.
   input  ncpu_pkg::issue_t          issue,
   input  logic                      issue_valid,
   output logic                      issue_ready,

   // Downstream back-pressure.
   input  logic                      hold,

   // Register file read port.
   output ncpu_pkg::reg_idx_t        raddr_a,
   output ncpu_pkg::reg_idx_t        raddr_b,
   output logic                      re,
   input  logic [ncpu_pkg::xlen-1:0] rdata_a,
   input  logic [ncpu_pkg::xlen-1:0] rdata_b,

   // Output to the next stage.
   output ncpu_pkg::operand_t        operand,
   output logic                      operand_valid
);

   import ncpu_pkg::*;

   // Control fields that travel with the read.
   op_e      opcode_q;
   reg_idx_t rd_q;
   logic     valid_q;

   // Stage advances whenever downstream does not hold.
   logic advance;

   assign advance = !hold;

   // The stage is one deep and always drains unless held.
   // So it can take a new instruction exactly when it advances.
   assign issue_ready = advance;

   // Read addresses come straight from the issue fields.
   assign raddr_a = issue.rs1;
   assign raddr_b = issue.rs2;

   // The reads run every cycle the stage advances.
   // A read during a bubble is harmless since valid_q marks it empty.
   // Keeping re low under hold is what keeps the RAM outputs frozen.
   assign re = advance;

   // Opcode and destination are captured in the same cycle as the reads.
   // They line up with the RAM read data one cycle later.
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         opcode_q <= op_nop;
         rd_q     <= '0;
         valid_q  <= 1'b0;
      end else if (advance) begin
         opcode_q <= issue.opcode;
         rd_q     <= issue.rd;
         valid_q  <= issue_valid;
      end
   end

   // Register values are taken directly from the register file.
   // Its read registers hold still under hold as well.
   // A write during a hold lands in the array only, not in the held word.
   always_comb begin
      operand.opcode  = opcode_q;
      operand.rd      = rd_q;
      operand.rs1_val = rdata_a;
      operand.rs2_val = rdata_b;
   end

   assign operand_valid = valid_q;

endmodule

//--- regfile/regfile.sv
////////////////////
// Register file with two read ports and one write port.
// Built from two RAM cells that share the write port.
// Register 0 reads as zero and ignores writes.
////////////////////

module regfile (
   input  logic                      clk,
   input  logic                      rst_n,
   input  ncpu_pkg::reg_idx_t        raddr_a,
   input  ncpu_pkg::reg_idx_t        raddr_b,
   input  logic                      re,
   input  ncpu_pkg::wb_t             wb,
   output logic [ncpu_pkg::xlen-1:0] rdata_a,
   output logic [ncpu_pkg::xlen-1:0] rdata_b
);

   import ncpu_pkg::*;

   // Write enable with register 0 taken out.
   logic wr_en;

   // Raw words from the two RAM cells.
   logic [xlen-1:0] ram_a;
   logic [xlen-1:0] ram_b;

   // Set when the last read on a port addressed register 0.
   logic zero_a_q;
   logic zero_b_q;

   // A write to register 0 never reaches the array.
   // This also keeps the bypass from forwarding into register 0.
   assign wr_en = wb.we && (wb.rd != '0);

   // Port A cell.
   // Both cells see every write, so they always hold the same contents.
   sdpram_sclk #(
      .aw            (rf_aw),
      .dw            (xlen),
      .enable_bypass (1'b1),
      .clear_on_init (1'b0)
   ) u_ram_a (
      .clk   (clk),
      .rst_n (rst_n),
      .raddr (raddr_a),
      .re    (re),
      .waddr (wb.rd),
      .we    (wr_en),
      .din   (wb.data),
      .dout  (ram_a)
   );

   // Port B cell.
   sdpram_sclk #(
      .aw            (rf_aw),
      .dw            (xlen),
      .enable_bypass (1'b1),
      .clear_on_init (1'b0)
   ) u_ram_b (
      .clk   (clk),
      .rst_n (rst_n),
      .raddr (raddr_b),
      .re    (re),
      .waddr (wb.rd),
      .we    (wr_en),
      .din   (wb.data),
      .dout  (ram_b)
   );

   // The zero flags move with re, just like the RAM read registers.
   // They come out of reset set, so both ports read zero before any read.
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         zero_a_q <= 1'b1;
         zero_b_q <= 1'b1;
      end else if (re) begin
         zero_a_q <= (raddr_a == '0);
         zero_b_q <= (raddr_b == '0);
      end
   end

   // Register 0 is masked here, whatever the array holds at that address.
   assign rdata_a = zero_a_q ? '0 : ram_a;
   assign rdata_b = zero_b_q ? '0 : ram_b;

endmodule

//--- logic/sdpram_sclk.sv
////////////////////
// Simple dual-port synchronous RAM cell.
// One write port and one registered read port on a single clock.
// An optional bypass returns the write data when a read and a
// write hit the same address in the same cycle.
////////////////////

module sdpram_sclk #(
   parameter int aw            = 5,
   parameter int dw            = 32,
   parameter bit enable_bypass = 1'b1,
   parameter bit clear_on_init = 1'b1
) (
   input  logic          clk,
   input  logic          rst_n,
   input  logic [aw-1:0] raddr,
   input  logic          re,
   input  logic [aw-1:0] waddr,
   input  logic          we,
   input  logic [dw-1:0] din,
   output logic [dw-1:0] dout
);

   // Storage array, one word per address.
   logic [dw-1:0] mem [(1 << aw)];

   // Registered read word from the array.
   logic [dw-1:0] dout_q;

   // Simulation starts from a known all-zero array when requested.
   generate
      if (clear_on_init) begin : g_clear
         initial begin
            for (int i = 0; i < (1 << aw); i++) begin
               mem[i] = '0;
            end
         end
      end
   endgenerate

   // The write lands in the array on the clock edge.
   always @(posedge clk) begin
      if (we) begin
         mem[waddr] <= din;
      end
   end

   // The read port only moves when re is high.
   // With re low the last word stays on dout.
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         dout_q <= '0;
      end else if (re) begin
         dout_q <= mem[raddr];
      end
   end

   generate
      if (enable_bypass) begin : g_bypass
         logic          bypass_q;
         logic [dw-1:0] din_q;

         // Write data is sampled with every read so that it is at hand
         // when the bypass flag selects it.
         always_ff @(posedge clk) begin
            if (re) begin
               din_q <= din;
            end
         end

         // The flag follows each read and keeps its value between reads.
         // A held read therefore still shows the forwarded word.
         always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
               bypass_q <= 1'b0;
            end else if (re) begin
               bypass_q <= we && (waddr == raddr);
            end
         end

         assign dout = bypass_q ? din_q : dout_q;
      end else begin : g_no_bypass
         // Same-cycle collisions return the old array word.
         assign dout = dout_q;
      end
   endgenerate

endmodule

//--- common/ncpu_pkg.sv
////////////////////
// Shared definitions for the register-file read stage.
// Holds the data and index widths, the opcode encoding and the
// structs that carry issued instructions, fetched operands and
// writeback requests between the blocks.
////////////////////

package ncpu_pkg;

   // Data path width of the core.
   localparam int xlen = 32;

   // Register index width, giving 32 architectural registers.
   localparam int rf_aw = 5;

   // Opcode classes as seen by the read stage.
   // The stage never decodes them and only passes them downstream.
   typedef enum logic [2:0] {
      op_nop    = 3'd0,
      op_alu    = 3'd1,
      op_load   = 3'd2,
      op_store  = 3'd3,
      op_branch = 3'd4
   } op_e;

   // Architectural register index.
   typedef logic [rf_aw-1:0] reg_idx_t;

   // Decoded instruction as handed over by the issue stage.
   // Two source registers and one destination.
   typedef struct packed {
      op_e      opcode;
      reg_idx_t rs1;
      reg_idx_t rs2;
      reg_idx_t rd;
   } issue_t;

   // Instruction with both source values filled in.
   typedef struct packed {
      op_e             opcode;
      reg_idx_t        rd;
      logic [xlen-1:0] rs1_val;
      logic [xlen-1:0] rs2_val;
   } operand_t;

   // Result written back into the register file.
   // Nothing happens in a cycle where we is low.
   typedef struct packed {
      logic            we;
      reg_idx_t        rd;
      logic [xlen-1:0] data;
   } wb_t;

endpackage
